/* rtl/blas_pkg.sv */
`default_nettype none

package blas_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int NUM_TILES   = 4;
	localparam int MEM_DEPTH   = 64;
	localparam int ADDR_W      = 6;
	localparam int LEN_W       = 4;		// Run covers len+1 words
	localparam int DATA_W      = 32;
	localparam int TABLE_DEPTH = 4;		// Most commands in flight
	localparam int ISSUE_W     = $clog2(TABLE_DEPTH);

	////////////////////////////////////////
	// Basic types
	////////////////////////////////////////
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_AXPY,
		OP_DOT
	} opcode_t;

	typedef logic [NUM_TILES-1:0]	tile_mask_t;
	typedef logic [ADDR_W-1:0]		addr_t;
	typedef logic [LEN_W-1:0]		len_t;
	typedef logic [DATA_W-1:0]		data_t;
	typedef logic [ISSUE_W-1:0]		issue_no_t;

	////////////////////////////////////////
	// Command and completion records
	////////////////////////////////////////
	typedef struct packed {
		opcode_t	op;
		tile_mask_t	mask;
		addr_t		src;
		addr_t		dst;
		len_t		len;
		data_t		operand;	// Write data or alpha
	} blas_cmd_t;

	// Broadcast to every tile
	typedef struct packed {
		issue_no_t	issue_no;
		blas_cmd_t	cmd;
	} tile_instr_t;

	typedef struct packed {
		issue_no_t	issue_no;
		data_t		partial;
	} tile_done_t;

	typedef struct packed {
		issue_no_t	issue_no;
		data_t		result;
	} blas_rsp_t;

endpackage

`default_nettype wire

/* rtl/issue_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_ctrl (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					cmd_valid,
	output logic					cmd_ready,
	input  blas_pkg::blas_cmd_t		cmd,
	input  blas_pkg::tile_mask_t	tile_busy,
	input  logic					table_full,
	output logic					issue_valid,
	output blas_pkg::tile_instr_t	issue
);

	import blas_pkg::*;

	logic		live;			// Set on the first edge out of reset
	issue_no_t	issue_cnt;
	logic		tiles_free;

	////////////////////////////////////////
	// Acceptance
	////////////////////////////////////////

	// Only the tiles named by the command matter
	assign tiles_free = ~|(cmd.mask & tile_busy);

	assign cmd_ready   = live && tiles_free && !table_full;
	assign issue_valid = cmd_valid && cmd_ready;

	// Same cycle broadcast, no staging register
	assign issue = '{issue_no: issue_cnt, cmd: cmd};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			live <= 1'b0;
		end
		else begin
			live <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Issue numbering
	////////////////////////////////////////

	// ISSUE_W covers exactly TABLE_DEPTH entries so the counter wraps there
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			issue_cnt <= '0;
		end
		else if (issue_valid) begin
			issue_cnt <= issue_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/commit_agg.sv */
`timescale 1ns/10ps
`default_nettype none

module commit_agg (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					issue_valid,
	input  blas_pkg::tile_instr_t	issue,
	input  blas_pkg::tile_mask_t	done_valid,
	input  blas_pkg::tile_done_t	done [blas_pkg::NUM_TILES],
	output logic					table_full,
	output logic					rsp_valid,
	input  logic					rsp_ready,
	output blas_pkg::blas_rsp_t		rsp
);

	import blas_pkg::*;

	tile_mask_t			pending  [TABLE_DEPTH];	// Tiles still running
	tile_mask_t			pend_nxt [TABLE_DEPTH];
	data_t				sum      [TABLE_DEPTH];
	data_t				sum_nxt  [TABLE_DEPTH];

	issue_no_t			head;
	issue_no_t			tail;
	logic [ISSUE_W:0]	count;

	logic				commit;
	logic				take;

	assign table_full = (count == (ISSUE_W+1)'(TABLE_DEPTH));
	assign take       = rsp_valid && rsp_ready;

	// Head entry stays in the table until its response is taken
	assign commit = (count != '0) && (pending[head] == '0) && !rsp_valid;

	////////////////////////////////////////
	// Entry update
	////////////////////////////////////////
	always_comb begin
		pend_nxt = pending;
		sum_nxt  = sum;
		// Several tiles may hit one entry in the same cycle
		for (int t = 0; t < NUM_TILES; t++) begin
			if (done_valid[t]) begin
				pend_nxt[done[t].issue_no][t] = 1'b0;
				sum_nxt[done[t].issue_no]     = sum_nxt[done[t].issue_no] + done[t].partial;
			end
		end
		if (issue_valid) begin
			pend_nxt[tail] = issue.cmd.mask;	// Empty mask opens as complete
			sum_nxt[tail]  = '0;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= '{default: '0};
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			rsp_valid <= 1'b0;
		end
		else begin
			pending <= pend_nxt;
			if (issue_valid)
				tail <= tail + 1'b1;
			if (take)
				head <= head + 1'b1;
			case ({issue_valid, take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (commit)
				rsp_valid <= 1'b1;
			else if (take)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		sum <= sum_nxt;
		if (commit)
			rsp <= '{issue_no: head, result: sum[head]};
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Commit table must have room for every broadcast
	a_no_issue_when_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		issue_valid |-> !table_full
	);

	a_issue_at_tail: assert property (
		@(posedge clock) disable iff (!rst_n)
		issue_valid |-> (issue.issue_no == tail)
	);

	for (genvar t = 0; t < NUM_TILES; t++) begin : g_chk
		a_done_pending: assert property (
			@(posedge clock) disable iff (!rst_n)
			done_valid[t] |-> pending[done[t].issue_no][t]
		);
	end

	a_rsp_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
	);

endmodule

`default_nettype wire

/* rtl/tile_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_unit #(
	parameter int TILE_ID = 0
) (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					issue_valid,
	input  blas_pkg::tile_instr_t	issue,
	output logic					busy,
	output logic					done_valid,
	output blas_pkg::tile_done_t	done
);

	import blas_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,		// One word per cycle
		ST_DONE
	} state_t;

	state_t		state;
	logic		accept;

	data_t		mem [MEM_DEPTH];

	opcode_t	op;
	issue_no_t	issue_no;
	addr_t		src_ptr;
	addr_t		dst_ptr;
	len_t		remain;
	data_t		alpha;
	data_t		acc;		// Dot sum or read word

	data_t		src_word;
	data_t		dst_word;
	data_t		product;

	assign accept = issue_valid && issue.cmd.mask[TILE_ID];

	assign src_word = mem[src_ptr];
	assign dst_word = mem[dst_ptr];
	assign product  = (op == OP_AXPY) ? alpha * src_word : src_word * dst_word;

	assign busy       = (state != ST_IDLE);
	assign done_valid = (state == ST_DONE);
	assign done       = '{issue_no: issue_no, partial: acc};

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (issue.cmd.op == OP_AXPY || issue.cmd.op == OP_DOT)
							state <= ST_RUN;
						else
							state <= ST_DONE;	// Write and read finish at once
					end
				end
				ST_RUN: begin
					if (remain == '0)
						state <= ST_DONE;
				end
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Data path and local memory
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			op       <= issue.cmd.op;
			issue_no <= issue.issue_no;
			src_ptr  <= issue.cmd.src;
			dst_ptr  <= issue.cmd.dst;
			remain   <= issue.cmd.len;
			alpha    <= issue.cmd.operand;
			acc      <= (issue.cmd.op == OP_READ) ? mem[issue.cmd.src] : '0;
			if (issue.cmd.op == OP_WRITE)
				mem[issue.cmd.dst] <= issue.cmd.operand;
		end
		else if (state == ST_RUN) begin
			src_ptr <= src_ptr + 1'b1;		// Wraps inside the memory
			dst_ptr <= dst_ptr + 1'b1;
			remain  <= remain - 1'b1;
			if (op == OP_AXPY)
				mem[dst_ptr] <= product + dst_word;
			else
				acc <= acc + product;
		end
	end

	// Issue side must respect this tile's busy flag
	a_no_issue_while_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		accept |-> !busy
	);

endmodule

`default_nettype wire

/* rtl/blas_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module blas_engine (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					cmd_valid,
	output logic					cmd_ready,
	input  blas_pkg::blas_cmd_t		cmd,
	output logic					rsp_valid,
	input  logic					rsp_ready,
	output blas_pkg::blas_rsp_t		rsp
);

	import blas_pkg::*;

	logic			issue_valid;
	tile_instr_t	issue;
	logic			table_full;

	tile_mask_t		tile_busy;
	tile_mask_t		done_valid;
	tile_done_t		done [NUM_TILES];

	////////////////////////////////////////
	// Front end
	////////////////////////////////////////
	issue_ctrl issue_ctrl (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.cmd_valid(		cmd_valid		),
		.cmd_ready(		cmd_ready		),
		.cmd(			cmd				),
		.tile_busy(		tile_busy		),
		.table_full(	table_full		),
		.issue_valid(	issue_valid		),
		.issue(			issue			)
	);

	////////////////////////////////////////
	// In-order commit
	////////////////////////////////////////
	commit_agg commit_agg (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.issue_valid(	issue_valid		),
		.issue(			issue			),
		.done_valid(	done_valid		),
		.done(			done			),
		.table_full(	table_full		),
		.rsp_valid(		rsp_valid		),
		.rsp_ready(		rsp_ready		),
		.rsp(			rsp				)
	);

	////////////////////////////////////////
	// Tile array
	////////////////////////////////////////
	for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
		tile_unit #(
			.TILE_ID(		t				)
		) tile_unit (
			.clock(			clock			),
			.rst_n(			rst_n			),
			.issue_valid(	issue_valid		),
			.issue(			issue			),
			.busy(			tile_busy[t]	),
			.done_valid(	done_valid[t]	),
			.done(			done[t]			)
		);
	end

endmodule

`default_nettype wire

/* tests/tb_blas_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_blas_engine;

	import blas_pkg::*;

	logic			clock;
	logic			rst_n;
	logic			cmd_valid;
	logic			cmd_ready;
	blas_cmd_t		cmd;
	logic			rsp_valid;
	logic			rsp_ready;
	blas_rsp_t		rsp;

	data_t		shadow  [NUM_TILES][MEM_DEPTH];	// Reference copy of each tile memory
	data_t		exp_res [1024];					// Expected results in issue order
	data_t		exp_head;
	int			exp_wr;
	int			acc_cnt;
	int			rsp_cnt;
	int			err_cnt;
	int			err_mark;
	int			tests_run;
	int			tests_failed;
	int			ready_mode;		// 0 always ready, 1 random stalls, 2 held low
	logic		stall_chk;
	logic		timed_out;
	logic		cmd_fire;
	logic		rsp_fire;

	blas_engine DUT (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.cmd_valid(	cmd_valid	),
		.cmd_ready(	cmd_ready	),
		.cmd(		cmd			),
		.rsp_valid(	rsp_valid	),
		.rsp_ready(	rsp_ready	),
		.rsp(		rsp			)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Response back-pressure
	initial begin
		rsp_ready = 1'b0;
		forever begin
			@(negedge clock);
			case (ready_mode)
				0:       rsp_ready = 1'b1;
				1:       rsp_ready = (($urandom % 4) != 0);
				default: rsp_ready = 1'b0;
			endcase
		end
	end

	////////////////////////////////////////
	// Transfer tracking and checks
	////////////////////////////////////////
	assign rsp_fire = rsp_valid && rsp_ready;
	assign exp_head = exp_res[rsp_cnt[9:0]];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cmd_fire <= 1'b0;
			acc_cnt  <= 0;
			rsp_cnt  <= 0;
		end
		else begin
			cmd_fire <= cmd_valid && cmd_ready;
			if (cmd_valid && cmd_ready)
				acc_cnt <= acc_cnt + 1;
			if (rsp_fire)
				rsp_cnt <= rsp_cnt + 1;
		end
	end

	a_rsp_value: assert property (
		@(posedge clock) disable iff (!rst_n)
		rsp_fire |-> (rsp.result == exp_head)
	) else begin
		err_cnt++;
		$display("FAILED at %0t: response %0d result %h, expected %h", $time,
			$sampled(rsp_cnt), $sampled(rsp.result), $sampled(exp_head));
	end

	a_rsp_order: assert property (
		@(posedge clock) disable iff (!rst_n)
		rsp_fire |-> (rsp.issue_no == issue_no_t'(rsp_cnt))
	) else begin
		err_cnt++;
		$display("FAILED at %0t: response %0d carries issue number %0d", $time,
			$sampled(rsp_cnt), $sampled(rsp.issue_no));
	end

	a_inflight: assert property (
		@(posedge clock) disable iff (!rst_n)
		(acc_cnt - rsp_cnt) <= TABLE_DEPTH
	) else begin
		err_cnt++;
		$display("FAILED at %0t: %0d commands in flight", $time, $sampled(acc_cnt - rsp_cnt));
	end

	a_full_blocks: assert property (
		@(posedge clock) disable iff (!rst_n)
		stall_chk |-> !cmd_ready
	) else begin
		err_cnt++;
		$display("FAILED at %0t: cmd_ready high with a full commit table", $time);
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	task automatic model_cmd(input blas_cmd_t c, output data_t res);
		data_t	part;
		addr_t	s;
		addr_t	d;
		res = '0;
		for (int t = 0; t < NUM_TILES; t++) begin
			if (c.mask[t]) begin
				part = '0;
				s = c.src;
				d = c.dst;
				case (c.op)
					OP_WRITE: shadow[t][c.dst] = c.operand;
					OP_READ:  part = shadow[t][c.src];
					OP_AXPY: begin
						for (int i = 0; i <= int'(c.len); i++) begin
							shadow[t][d] = c.operand * shadow[t][s] + shadow[t][d];
							s = s + 1'b1;	// Wraps like the tile pointers
							d = d + 1'b1;
						end
					end
					default: begin
						for (int i = 0; i <= int'(c.len); i++) begin
							part = part + shadow[t][s] * shadow[t][d];
							s = s + 1'b1;
							d = d + 1'b1;
						end
					end
				endcase
				res = res + part;
			end
		end
	endtask

	function automatic blas_cmd_t make_cmd(input opcode_t op, input tile_mask_t mask,
			input addr_t src, input addr_t dst, input len_t run, input data_t operand);
		blas_cmd_t c;
		c.op      = op;
		c.mask    = mask;
		c.src     = src;
		c.dst     = dst;
		c.len     = run;
		c.operand = operand;
		return c;
	endfunction

	function automatic tile_mask_t tile_bit(input int t);
		return tile_mask_t'(1) << t;
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	task automatic note_timeout(input string why);
		$display("Run stopped: %s", why);
		timed_out = 1'b1;
	endtask

	// Called on a falling edge
	task automatic drive_cmd(input blas_cmd_t c);
		data_t res;
		model_cmd(c, res);
		exp_res[exp_wr[9:0]] = res;
		exp_wr++;
		cmd       = c;
		cmd_valid = 1'b1;
	endtask

	task automatic wait_accept();
		int n;
		n = 0;
		if (timed_out) begin
			cmd_valid = 1'b0;
			return;
		end
		do begin
			@(negedge clock);
			n++;
		end while (!cmd_fire && n < 500);
		cmd_valid = 1'b0;
		if (!cmd_fire)
			note_timeout("a command was not accepted within 500 cycles");
	endtask

	task automatic send(input blas_cmd_t c);
		drive_cmd(c);
		wait_accept();
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (!timed_out && rsp_cnt != exp_wr && n < 4000) begin
			@(negedge clock);
			n++;
		end
		if (!timed_out && rsp_cnt != exp_wr)
			note_timeout("responses did not drain within 4000 cycles");
	endtask

	task automatic end_test(input string name);
		wait_drain();
		tests_run++;
		if (timed_out) begin
			tests_failed++;
			$display("test %0d %s: timed out", tests_run, name);
		end
		else if (err_cnt == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end
		else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		tile_mask_t	m;
		len_t		run;
		void'($urandom(32'h9e04_b0e6));
		rst_n        = 1'b0;
		cmd_valid    = 1'b0;
		cmd          = '0;
		ready_mode   = 0;
		stall_chk    = 1'b0;
		timed_out    = 1'b0;
		exp_wr       = 0;
		err_cnt      = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		for (int t = 0; t < NUM_TILES; t++) begin
			send(make_cmd(OP_WRITE, tile_bit(t), '0, addr_t'(40 + t), '0, $urandom));
			send(make_cmd(OP_READ, tile_bit(t), addr_t'(40 + t), '0, '0, '0));
		end
		for (int t = 0; t < NUM_TILES; t++)
			send(make_cmd(OP_WRITE, tile_bit(t), '0, 6'd48, '0, $urandom));
		send(make_cmd(OP_READ, 4'b1101, 6'd48, '0, '0, '0));	// Sum of three tiles
		send(make_cmd(OP_READ, 4'b1111, 6'd48, '0, '0, '0));
		end_test("write and read");

		ready_mode = 1;
		for (int t = 0; t < NUM_TILES; t++)
			for (int i = 0; i < 32; i++)
				send(make_cmd(OP_WRITE, tile_bit(t), '0, addr_t'(i), '0, $urandom));
		m = tile_mask_t'($urandom);
		if (m == '0)
			m = 4'b0110;
		run = len_t'($urandom);
		send(make_cmd(OP_AXPY, m, 6'd0, 6'd16, run, $urandom));
		for (int t = 0; t < NUM_TILES; t++)
			if (m[t])
				for (int i = 0; i <= int'(run); i++)
					send(make_cmd(OP_READ, tile_bit(t), addr_t'(16 + i), '0, '0, '0));
		end_test("axpy");

		send(make_cmd(OP_DOT, 4'b1111, 6'd0, 6'd16, 4'd15, '0));
		send(make_cmd(OP_DOT, 4'b1111, addr_t'($urandom % 16), 6'd16, len_t'($urandom), '0));
		end_test("dot on all tiles");

		// Long dot on tile 0, short reads overtake it on tile 1
		send(make_cmd(OP_DOT, tile_bit(0), 6'd0, 6'd16, 4'd15, '0));
		for (int i = 0; i < 3; i++)
			send(make_cmd(OP_READ, tile_bit(1), addr_t'(16 + i), '0, '0, '0));
		send(make_cmd(OP_READ, tile_bit(0), 6'd20, '0, '0, '0));
		end_test("out of order finish");

		ready_mode = 2;
		@(negedge clock);
		for (int i = 0; i < TABLE_DEPTH; i++)
			send(make_cmd(OP_READ, tile_bit(i % NUM_TILES), addr_t'(16 + i), '0, '0, '0));
		drive_cmd(make_cmd(OP_READ, tile_bit(2), 6'd42, '0, '0, '0));
		stall_chk = 1'b1;
		repeat (12) @(negedge clock);
		stall_chk  = 1'b0;
		ready_mode = 0;
		wait_accept();
		end_test("back-pressure");

		ready_mode = 1;
		send(make_cmd(OP_DOT, tile_bit(2), 6'd0, 6'd16, 4'd15, '0));
		send(make_cmd(OP_READ, 4'b0000, 6'd0, '0, '0, '0));
		send(make_cmd(OP_WRITE, 4'b0000, '0, 6'd0, '0, $urandom));
		send(make_cmd(OP_READ, tile_bit(3), 6'd43, '0, '0, '0));
		end_test("empty mask");

		$display("%0d tests run, %0d failed, %0d responses checked, %0d check errors",
			tests_run, tests_failed, rsp_cnt, err_cnt);
		if (!timed_out && tests_failed == 0 && err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/blas_pkg.sv
rtl/issue_ctrl.sv
rtl/commit_agg.sv
rtl/tile_unit.sv
rtl/blas_engine.sv
tests/tb_blas_engine.sv

/* Makefile */
TOP = tb_blas_engine

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
